//--- source/tpl_regmap_pkg.sv
// Shared address map and constants of the DAC transport layer register map.
// Imported by every block that decodes or answers processor bus accesses.

`default_nettype none

package tpl_regmap_pkg;

  typedef logic [9:0]  up_addr_t;
  typedef logic [31:0] up_data_t;

  localparam int unsigned NUM_CHANNELS = 4;

  localparam up_data_t CORE_VERSION = 32'h0001_0361;
  localparam up_data_t CORE_ID      = 32'h0000_0000;

  // ******************************
  // Common block
  // ******************************
  localparam up_addr_t ADDR_VERSION = 10'h000;
  localparam up_addr_t ADDR_ID      = 10'h001;
  localparam up_addr_t ADDR_SCRATCH = 10'h002;
  localparam up_addr_t ADDR_RSTN    = 10'h010;
  localparam up_addr_t ADDR_SYNC    = 10'h011;
  localparam up_addr_t ADDR_FORMAT  = 10'h012;
  localparam up_addr_t ADDR_STATUS  = 10'h020;

  // ******************************
  // Channel region
  // ******************************
  localparam up_addr_t CHAN_BASE   = 10'h100;
  localparam up_addr_t CHAN_STRIDE = 10'h010;
  localparam up_addr_t CHAN_END    = CHAN_BASE + up_addr_t'(NUM_CHANNELS * CHAN_STRIDE);

  // Offset bits within a window, channel index bits above them
  localparam int unsigned OFS_W  = $clog2(CHAN_STRIDE);
  localparam int unsigned CHAN_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

  typedef logic [OFS_W-1:0] chan_ofs_t;

  localparam chan_ofs_t OFS_SCALE    = chan_ofs_t'(0);
  localparam chan_ofs_t OFS_INCR     = chan_ofs_t'(1);
  localparam chan_ofs_t OFS_PATTERN  = chan_ofs_t'(2);
  localparam chan_ofs_t OFS_DATA_SEL = chan_ofs_t'(3);

endpackage

`default_nettype wire

//--- source/up_reg_bus_if.sv
// Internal processor bus between the combiner and one register block.
// One instance per block; the combiner drives requests, the block answers.

`timescale 1ns/100ps
`default_nettype none

interface up_reg_bus_if;

  import tpl_regmap_pkg::*;

  // Requests, single cycle strobes
  logic     wreq;
  up_addr_t waddr;
  up_data_t wdata;
  logic     rreq;
  up_addr_t raddr;

  // Answers, rdata is zero outside rack
  logic     wack;
  up_data_t rdata;
  logic     rack;

  modport host (
    output wreq, waddr, wdata, rreq, raddr,
    input  wack, rdata, rack
  );

  modport block (
    input  wreq, waddr, wdata, rreq, raddr,
    output wack, rdata, rack
  );

endinterface

`default_nettype wire

//--- source/up_dac_common.sv
// Common register block: identification, scratch, DAC reset release,
// sync request pulse, data format and the sticky underflow status.
// Answers only the listed addresses below the channel region.

`timescale 1ns/100ps
`default_nettype none

module up_dac_common (
  input  logic        up_clk,
  input  logic        up_rstn,
  up_reg_bus_if.block bus,
  input  logic        dac_dunf,
  input  logic        dac_sync_in_status,
  output logic        dac_rst,
  output logic        dac_sync,
  output logic        dac_dds_format
);

  import tpl_regmap_pkg::*;

  logic     up_resetn;
  logic     up_sync;
  logic     up_format;
  logic     up_dunf_sticky;
  up_data_t up_scratch;
  logic     w_hit;
  logic     r_hit;
  up_data_t r_word;

  function automatic logic addr_listed(up_addr_t a);
    return (a == ADDR_VERSION) || (a == ADDR_ID) || (a == ADDR_SCRATCH) ||
           (a == ADDR_RSTN) || (a == ADDR_SYNC) || (a == ADDR_FORMAT) ||
           (a == ADDR_STATUS);
  endfunction

  assign w_hit = addr_listed(bus.waddr);
  assign r_hit = addr_listed(bus.raddr);

  // ******************************
  // Write side
  // ******************************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_scratch <= '0;
      up_resetn  <= 1'b0;
      up_format  <= 1'b0;
    end else if (bus.wreq) begin
      case (bus.waddr)
        ADDR_SCRATCH: up_scratch <= bus.wdata;
        ADDR_RSTN:    up_resetn  <= bus.wdata[0];
        ADDR_FORMAT:  up_format  <= bus.wdata[4];
        default: ;
      endcase
    end
  end

  // Sync request lasts one cycle after the write
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_sync <= 1'b0;
    end else begin
      up_sync <= bus.wreq && (bus.waddr == ADDR_SYNC) && bus.wdata[0];
    end
  end

  // Underflow flag, set wins over a clear in the same cycle
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_dunf_sticky <= 1'b0;
    end else if (dac_dunf) begin
      up_dunf_sticky <= 1'b1;
    end else if (bus.wreq && (bus.waddr == ADDR_STATUS) && bus.wdata[0]) begin
      up_dunf_sticky <= 1'b0;
    end
  end

  // ******************************
  // Read side
  // ******************************
  always_comb begin
    case (bus.raddr)
      ADDR_VERSION: r_word = CORE_VERSION;
      ADDR_ID:      r_word = CORE_ID;
      ADDR_SCRATCH: r_word = up_scratch;
      ADDR_RSTN:    r_word = {31'd0, up_resetn};
      ADDR_FORMAT:  r_word = {27'd0, up_format, 4'd0};
      ADDR_STATUS:  r_word = {30'd0, dac_sync_in_status, up_dunf_sticky};
      default:      r_word = '0;
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      bus.wack  <= 1'b0;
      bus.rack  <= 1'b0;
      bus.rdata <= '0;
    end else begin
      bus.wack  <= bus.wreq && w_hit;
      bus.rack  <= bus.rreq && r_hit;
      bus.rdata <= (bus.rreq && r_hit) ? r_word : '0;
    end
  end

  assign dac_rst        = ~up_resetn;
  assign dac_sync       = up_sync;
  assign dac_dds_format = up_format;

endmodule

`default_nettype wire

//--- source/up_dac_channel_bank.sv
// Channel register bank: DDS scale, DDS increment, pattern data and data
// select for every DAC channel, one window of CHAN_STRIDE words each.
// Register values leave the bank as flattened per-channel vectors.

`timescale 1ns/100ps
`default_nettype none

module up_dac_channel_bank (
  input  logic                                         up_clk,
  input  logic                                         up_rstn,
  up_reg_bus_if.block                                  bus,
  output logic [tpl_regmap_pkg::NUM_CHANNELS*16-1:0]   dac_dds_scale,
  output logic [tpl_regmap_pkg::NUM_CHANNELS*16-1:0]   dac_dds_incr,
  output logic [tpl_regmap_pkg::NUM_CHANNELS*16-1:0]   dac_pat_data,
  output logic [tpl_regmap_pkg::NUM_CHANNELS*4-1:0]    dac_data_sel
);

  import tpl_regmap_pkg::*;

  logic [15:0]       up_scale    [NUM_CHANNELS];
  logic [15:0]       up_incr     [NUM_CHANNELS];
  logic [15:0]       up_pattern  [NUM_CHANNELS];
  logic [3:0]        up_data_sel [NUM_CHANNELS];
  up_addr_t          w_rel;
  up_addr_t          r_rel;
  logic [CHAN_W-1:0] w_chan;
  logic [CHAN_W-1:0] r_chan;
  chan_ofs_t         w_ofs;
  chan_ofs_t         r_ofs;
  logic              w_hit;
  logic              r_hit;
  up_data_t          r_word;

  // Inside the region and on one of the four used offsets
  function automatic logic chan_hit(up_addr_t a);
    return (a >= CHAN_BASE) && (a < CHAN_END) && (a[OFS_W-1:0] <= OFS_DATA_SEL);
  endfunction

  assign w_rel  = bus.waddr - CHAN_BASE;
  assign r_rel  = bus.raddr - CHAN_BASE;
  assign w_chan = w_rel[OFS_W +: CHAN_W];
  assign r_chan = r_rel[OFS_W +: CHAN_W];
  assign w_ofs  = w_rel[OFS_W-1:0];
  assign r_ofs  = r_rel[OFS_W-1:0];
  assign w_hit  = chan_hit(bus.waddr);
  assign r_hit  = chan_hit(bus.raddr);

  // ******************************
  // Register writes
  // ******************************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        up_scale[i]    <= '0;
        up_incr[i]     <= '0;
        up_pattern[i]  <= '0;
        up_data_sel[i] <= '0;
      end
    end else if (bus.wreq && w_hit) begin
      case (w_ofs)
        OFS_SCALE:    up_scale[w_chan]    <= bus.wdata[15:0];
        OFS_INCR:     up_incr[w_chan]     <= bus.wdata[15:0];
        OFS_PATTERN:  up_pattern[w_chan]  <= bus.wdata[15:0];
        OFS_DATA_SEL: up_data_sel[w_chan] <= bus.wdata[3:0];
        default: ;
      endcase
    end
  end

  // Readback, zero extended
  always_comb begin
    case (r_ofs)
      OFS_SCALE:    r_word = {16'd0, up_scale[r_chan]};
      OFS_INCR:     r_word = {16'd0, up_incr[r_chan]};
      OFS_PATTERN:  r_word = {16'd0, up_pattern[r_chan]};
      OFS_DATA_SEL: r_word = {28'd0, up_data_sel[r_chan]};
      default:      r_word = '0;
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      bus.wack  <= 1'b0;
      bus.rack  <= 1'b0;
      bus.rdata <= '0;
    end else begin
      bus.wack  <= bus.wreq && w_hit;
      bus.rack  <= bus.rreq && r_hit;
      bus.rdata <= (bus.rreq && r_hit) ? r_word : '0;
    end
  end

  // ******************************
  // Flattened outputs
  // ******************************
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_flat
    assign dac_dds_scale[16*c +: 16] = up_scale[c];
    assign dac_dds_incr[16*c +: 16]  = up_incr[c];
    assign dac_pat_data[16*c +: 16]  = up_pattern[c];
    assign dac_data_sel[4*c +: 4]    = up_data_sel[c];
  end

endmodule

`default_nettype wire

//--- source/up_regmap_combiner.sv
// Sends every host request to both register blocks and merges the answers.
// Adds one registered stage, so the host sees acknowledges two cycles
// after its request.

`timescale 1ns/100ps
`default_nettype none

module up_regmap_combiner (
  input  logic                     up_clk,
  input  logic                     up_rstn,
  input  logic                     up_wreq,
  input  tpl_regmap_pkg::up_addr_t up_waddr,
  input  tpl_regmap_pkg::up_data_t up_wdata,
  input  logic                     up_rreq,
  input  tpl_regmap_pkg::up_addr_t up_raddr,
  output logic                     up_wack,
  output logic                     up_rack,
  output tpl_regmap_pkg::up_data_t up_rdata,
  up_reg_bus_if.host               common_bus,
  up_reg_bus_if.host               chan_bus
);

  import tpl_regmap_pkg::*;

  up_data_t rdata_merged;

  // Same request to both blocks, only one of them answers
  assign common_bus.wreq  = up_wreq;
  assign common_bus.waddr = up_waddr;
  assign common_bus.wdata = up_wdata;
  assign common_bus.rreq  = up_rreq;
  assign common_bus.raddr = up_raddr;
  assign chan_bus.wreq    = up_wreq;
  assign chan_bus.waddr   = up_waddr;
  assign chan_bus.wdata   = up_wdata;
  assign chan_bus.rreq    = up_rreq;
  assign chan_bus.raddr   = up_raddr;

  // Idle blocks drive zero read data
  assign rdata_merged = common_bus.rdata | chan_bus.rdata;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack  <= 1'b0;
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_wack  <= common_bus.wack | chan_bus.wack;
      up_rack  <= common_bus.rack | chan_bus.rack;
      up_rdata <= rdata_merged;
    end
  end

endmodule

`default_nettype wire

//--- source/tpl_dac_regmap.sv
// Top level of the DAC transport layer register map.
// Takes the processor bus as plain ports and drives the DAC control outputs.

`timescale 1ns/100ps
`default_nettype none

module tpl_dac_regmap (
  input  logic                                        up_clk,
  input  logic                                        up_rstn,
  input  logic                                        up_wreq,
  input  tpl_regmap_pkg::up_addr_t                    up_waddr,
  input  tpl_regmap_pkg::up_data_t                    up_wdata,
  output logic                                        up_wack,
  input  logic                                        up_rreq,
  input  tpl_regmap_pkg::up_addr_t                    up_raddr,
  output tpl_regmap_pkg::up_data_t                    up_rdata,
  output logic                                        up_rack,
  input  logic                                        dac_dunf,
  input  logic                                        dac_sync_in_status,
  output logic                                        dac_rst,
  output logic                                        dac_sync,
  output logic                                        dac_dds_format,
  output logic [tpl_regmap_pkg::NUM_CHANNELS*16-1:0]  dac_dds_scale,
  output logic [tpl_regmap_pkg::NUM_CHANNELS*16-1:0]  dac_dds_incr,
  output logic [tpl_regmap_pkg::NUM_CHANNELS*16-1:0]  dac_pat_data,
  output logic [tpl_regmap_pkg::NUM_CHANNELS*4-1:0]   dac_data_sel
);

  up_reg_bus_if common_bus ();
  up_reg_bus_if chan_bus ();

  up_regmap_combiner i_combiner (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .up_wreq    (up_wreq),
    .up_waddr   (up_waddr),
    .up_wdata   (up_wdata),
    .up_rreq    (up_rreq),
    .up_raddr   (up_raddr),
    .up_wack    (up_wack),
    .up_rack    (up_rack),
    .up_rdata   (up_rdata),
    .common_bus (common_bus.host),
    .chan_bus   (chan_bus.host)
  );

  up_dac_common i_common (
    .up_clk             (up_clk),
    .up_rstn            (up_rstn),
    .bus                (common_bus.block),
    .dac_dunf           (dac_dunf),
    .dac_sync_in_status (dac_sync_in_status),
    .dac_rst            (dac_rst),
    .dac_sync           (dac_sync),
    .dac_dds_format     (dac_dds_format)
  );

  up_dac_channel_bank i_channels (
    .up_clk        (up_clk),
    .up_rstn       (up_rstn),
    .bus           (chan_bus.block),
    .dac_dds_scale (dac_dds_scale),
    .dac_dds_incr  (dac_dds_incr),
    .dac_pat_data  (dac_pat_data),
    .dac_data_sel  (dac_data_sel)
  );

endmodule

`default_nettype wire

//--- verif/tpl_dac_regmap_checker.sv
// Bus timing and sync pulse assertions for the register map top level.
// Attached to the top level with bind from the testbench.

`timescale 1ns/100ps
`default_nettype none

module tpl_dac_regmap_checker (
  input logic                     up_clk,
  input logic                     up_rstn,
  input logic                     up_wreq,
  input tpl_regmap_pkg::up_addr_t up_waddr,
  input logic                     up_rreq,
  input tpl_regmap_pkg::up_addr_t up_raddr,
  input logic                     up_wack,
  input logic                     up_rack,
  input tpl_regmap_pkg::up_data_t up_rdata,
  input logic                     dac_sync
);

  import tpl_regmap_pkg::*;

  function automatic logic mapped(up_addr_t a);
    logic common_hit;
    logic chan_hit;
    common_hit = (a == ADDR_VERSION) || (a == ADDR_ID) || (a == ADDR_SCRATCH) ||
                 (a == ADDR_RSTN) || (a == ADDR_SYNC) || (a == ADDR_FORMAT) ||
                 (a == ADDR_STATUS);
    chan_hit = (a >= CHAN_BASE) && (a < CHAN_END) && (a[OFS_W-1:0] <= OFS_DATA_SEL);
    return common_hit || chan_hit;
  endfunction

  // ******************************
  // Acknowledge timing
  // ******************************
  a_wack_single: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wack |=> !up_wack) else $error("up_wack high for two cycles");

  a_rack_single: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rack |=> !up_rack) else $error("up_rack high for two cycles");

  a_wack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wreq && mapped(up_waddr) |-> ##2 up_wack)
    else $error("mapped write not acknowledged two cycles later");

  a_rack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rreq && mapped(up_raddr) |-> ##2 up_rack)
    else $error("mapped read not acknowledged two cycles later");

  // Idle read data must be zero
  a_rdata_idle: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !up_rack |-> up_rdata == '0) else $error("up_rdata nonzero without up_rack");

  a_sync_pulse: assert property (@(posedge up_clk) disable iff (!up_rstn)
    dac_sync |=> !dac_sync) else $error("dac_sync high for more than one cycle");

endmodule

`default_nettype wire

//--- verif/tpl_dac_regmap_tb.sv
// Testbench for the DAC transport layer register map top level.
// Replays verif/tpl_dac_regmap_vectors.txt (run from the project root) and checks
// read data, acknowledges and the DAC control outputs against a register model.

`timescale 1ns/100ps
`default_nettype none

module tpl_dac_regmap_tb;

  import tpl_regmap_pkg::*;

  localparam int    ACK_TIMEOUT = 16;
  localparam string VEC_FILE    = "verif/tpl_dac_regmap_vectors.txt";

  logic                         up_clk;
  logic                         up_rstn;
  logic                         up_wreq;
  logic                         up_rreq;
  up_addr_t                     up_waddr;
  up_addr_t                     up_raddr;
  up_data_t                     up_wdata;
  up_data_t                     up_rdata;
  logic                         up_wack;
  logic                         up_rack;
  logic                         dac_dunf;
  logic                         dac_sync_in_status;
  logic                         dac_rst;
  logic                         dac_sync;
  logic                         dac_dds_format;
  logic [NUM_CHANNELS*16-1:0]   dac_dds_scale;
  logic [NUM_CHANNELS*16-1:0]   dac_dds_incr;
  logic [NUM_CHANNELS*16-1:0]   dac_pat_data;
  logic [NUM_CHANNELS*4-1:0]    dac_data_sel;

  // Expected DAC side state
  logic [15:0] exp_scale [NUM_CHANNELS];
  logic [15:0] exp_incr  [NUM_CHANNELS];
  logic [15:0] exp_pat   [NUM_CHANNELS];
  logic [3:0]  exp_sel   [NUM_CHANNELS];
  logic        exp_rst;
  logic        exp_format;
  int          sync_hits;
  int          value_errors;
  int          timeout_errors;
  int          other_errors;

  tpl_dac_regmap dut0 (.*);

  bind tpl_dac_regmap tpl_dac_regmap_checker chk0 (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_wack  (up_wack),
    .up_rack  (up_rack),
    .up_rdata (up_rdata),
    .dac_sync (dac_sync)
  );

  initial begin
    up_clk = 1'b0;
    forever #2 up_clk = ~up_clk;
  end

  // ******************************
  // Compare tasks
  // ******************************
  task automatic check_data(input string what, input up_data_t got, input up_data_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL t=%0t %s: got %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_chan(input string what, input logic [15:0] got,
                            input logic [15:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL t=%0t %s: got %04h, expected %04h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL t=%0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Every channel slice including untouched ones
  task automatic check_outputs();
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      check_chan($sformatf("ch%0d scale", c), dac_dds_scale[16*c +: 16], exp_scale[c]);
      check_chan($sformatf("ch%0d incr", c), dac_dds_incr[16*c +: 16], exp_incr[c]);
      check_chan($sformatf("ch%0d pattern", c), dac_pat_data[16*c +: 16], exp_pat[c]);
      check_chan($sformatf("ch%0d data_sel", c), {12'd0, dac_data_sel[4*c +: 4]},
                 {12'd0, exp_sel[c]});
    end
    check_bit("dac_rst", dac_rst, exp_rst);
    check_bit("dac_dds_format", dac_dds_format, exp_format);
  endtask

  task automatic report_timeout(input string kind, input up_addr_t addr);
    timeout_errors++;
    $display("Timeout: no %s acknowledge for address %03h after %0d cycles",
             kind, addr, ACK_TIMEOUT);
  endtask

  task automatic flag_stray_ack(input string kind, input up_addr_t addr);
    other_errors++;
    $display("Unexpected %s acknowledge from unmapped address %03h", kind, addr);
  endtask

  // ******************************
  // Bus access
  // ******************************
  task automatic write_reg(input up_addr_t addr, input up_data_t data, output logic acked);
    int cycles;
    cycles    = 0;
    sync_hits = 0;
    up_waddr  = addr;
    up_wdata  = data;
    up_wreq   = 1'b1;
    @(negedge up_clk);
    up_wreq = 1'b0;
    if (dac_sync) sync_hits++;
    while (!up_wack && cycles < ACK_TIMEOUT) begin
      @(negedge up_clk);
      if (dac_sync) sync_hits++;
      cycles++;
    end
    acked = up_wack;
    @(negedge up_clk);
    if (dac_sync) sync_hits++;
  endtask

  task automatic read_reg(input up_addr_t addr, output up_data_t data, output logic acked);
    int cycles;
    cycles   = 0;
    up_raddr = addr;
    up_rreq  = 1'b1;
    @(negedge up_clk);
    up_rreq = 1'b0;
    while (!up_rack && cycles < ACK_TIMEOUT) begin
      @(negedge up_clk);
      cycles++;
    end
    acked = up_rack;
    data  = up_rdata;
    @(negedge up_clk);
  endtask

  // Data bit 0 pulses underflow and bit 1 sets the sync-in level
  task automatic drive_status(input up_data_t data);
    dac_sync_in_status = data[1];
    dac_dunf           = data[0];
    @(negedge up_clk);
    dac_dunf = 1'b0;
    @(negedge up_clk);
  endtask

  // Register model from the address map
  task automatic apply_write(input up_addr_t addr, input up_data_t data);
    up_addr_t rel;
    int       ch;
    int       ofs;
    rel = addr - CHAN_BASE;
    ch  = int'(rel / CHAN_STRIDE);
    ofs = int'(rel % CHAN_STRIDE);
    if (addr == ADDR_RSTN) exp_rst = ~data[0];
    if (addr == ADDR_FORMAT) exp_format = data[4];
    if (addr >= CHAN_BASE && addr < CHAN_END) begin
      case (ofs)
        0: exp_scale[ch] = data[15:0];
        1: exp_incr[ch]  = data[15:0];
        2: exp_pat[ch]   = data[15:0];
        3: exp_sel[ch]   = data[3:0];
        default: ;
      endcase
    end
  endtask

  // ******************************
  // Main sequence
  // ******************************
  initial begin
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    up_addr_t   addr;
    up_data_t   data;
    up_data_t   expv;
    up_data_t   rd;
    logic       acked;

    value_errors       = 0;
    timeout_errors     = 0;
    other_errors       = 0;
    sync_hits          = 0;
    up_rstn            = 1'b0;
    up_wreq            = 1'b0;
    up_rreq            = 1'b0;
    up_waddr           = '0;
    up_raddr           = '0;
    up_wdata           = '0;
    dac_dunf           = 1'b0;
    dac_sync_in_status = 1'b0;
    exp_rst            = 1'b1;
    exp_format         = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      exp_scale[c] = '0;
      exp_incr[c]  = '0;
      exp_pat[c]   = '0;
      exp_sel[c]   = '0;
    end

    // Five rising edges in reset, release on the next falling edge
    repeat (5) @(posedge up_clk);
    @(negedge up_clk);
    up_rstn = 1'b1;
    @(negedge up_clk);
    check_bit("dac_sync after reset", dac_sync, 1'b0);
    check_outputs();

    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      other_errors++;
      $display("Cannot open the vectors file %s", VEC_FILE);
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 7 || line[0] == "#") continue;
        n = $sscanf(line, "%h %h %h %h", op, addr, data, expv);
        if (n != 4) continue;
        case (op)
          8'h01: begin
            write_reg(addr, data, acked);
            if (!acked) report_timeout("write", addr);
            apply_write(addr, data);
            check_bit("dac_sync pulse", sync_hits != 0, (addr == ADDR_SYNC) && data[0]);
            check_bit("dac_sync wider than a cycle", sync_hits > 1, 1'b0);
            read_reg(addr, rd, acked);
            if (!acked) report_timeout("read", addr);
            else check_data($sformatf("readback %03h", addr), rd, expv);
          end
          8'h02: begin
            read_reg(addr, rd, acked);
            if (!acked) report_timeout("read", addr);
            else check_data($sformatf("read %03h", addr), rd, expv);
          end
          8'h03: begin
            // Unmapped addresses must stay silent
            write_reg(addr, data, acked);
            if (acked) flag_stray_ack("write", addr);
            read_reg(addr, rd, acked);
            if (acked) flag_stray_ack("read", addr);
          end
          8'h04: drive_status(data);
          default: begin
            other_errors++;
            $display("Unknown operation %0h in the vectors file", op);
          end
        endcase
        check_outputs();
      end
      $fclose(fd);
    end

    $display("Errors: %0d value, %0d timeout, %0d other",
             value_errors, timeout_errors, other_errors);
    if (value_errors == 0 && timeout_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/tpl_dac_regmap_vectors.txt
# op addr data expect, all hex; op 1 write then read back, 2 read, 3 unmapped write and read
# op 4 drives status inputs: data bit 0 pulses dac_dunf, data bit 1 sets dac_sync_in_status
2 000 00000000 00010361
2 001 00000000 00000000
1 002 a5a55a5a a5a55a5a
1 002 0f1e2d3c 0f1e2d3c
1 011 00000001 00000000
1 010 00000001 00000001
1 012 00000010 00000010
1 100 00001111 00001111
1 101 00001112 00001112
1 102 ffff1113 00001113
1 103 000000a1 00000001
1 110 00002221 00002221
1 111 00002222 00002222
1 112 00002223 00002223
1 113 00000002 00000002
1 120 00003331 00003331
1 121 00003332 00003332
1 122 00003333 00003333
1 123 00000003 00000003
1 130 0000f441 0000f441
1 131 0000f442 0000f442
1 132 0000f443 0000f443
1 133 0000000c 0000000c
2 100 00000000 00001111
2 020 00000000 00000000
4 000 00000001 00000000
2 020 00000000 00000001
4 000 00000002 00000000
2 020 00000000 00000003
1 020 00000001 00000002
4 000 00000000 00000000
2 020 00000000 00000000
3 030 12345678 00000000
3 104 0000ffff 00000000
3 140 0000ffff 00000000
3 3ff 0000ffff 00000000
2 002 00000000 0f1e2d3c
1 012 00000000 00000000

//--- project.f
source/tpl_regmap_pkg.sv
source/up_reg_bus_if.sv
source/up_dac_common.sv
source/up_dac_channel_bank.sv
source/up_regmap_combiner.sv
source/tpl_dac_regmap.sv
verif/tpl_dac_regmap_checker.sv
verif/tpl_dac_regmap_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the register map testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f \
  --top-module tpl_dac_regmap_tb -o tpl_dac_regmap_sim
sim_out=$(./obj_dir/tpl_dac_regmap_sim || true)
echo "$sim_out"
if grep -qx "=== PASS ===" <<< "$sim_out"; then
  exit 0
fi
exit 1
